//--- src/stream_pkg.sv
package stream_pkg;

  // width of a sample word as it arrives from the acquisition front end
  localparam int DIN_WIDTH_DEF = 64;

  // width of one slice on the narrow side
  localparam int DOUT_WIDTH_DEF = 16;

  // buffer depth, kept a power of two so the pointers wrap on their own
  localparam int FIFO_DEPTH_DEF = 16;

  // free entries left when din_ready drops
  localparam int AF_MARGIN_DEF = 2;

  // wide sample word
  typedef logic [DIN_WIDTH_DEF-1:0] din_t;

  // narrow slice
  typedef logic [DOUT_WIDTH_DEF-1:0] dout_t;

endpackage

//--- src/ctrl_pkg.sv
package ctrl_pkg;

  // slice and drop counters both wrap at this width
  localparam int CNT_WIDTH = 16;

  typedef logic [CNT_WIDTH-1:0] cnt_t;

  // reducer FSM, idle until a word is waiting, then splitting it
  typedef enum logic {
    RED_IDLE,
    RED_SPLIT
  } reducer_state_e;

endpackage

//--- src/fifo_if.sv
`timescale 1ns/10ps

interface fifo_if #(
  parameter int DIN_WIDTH = stream_pkg::DIN_WIDTH_DEF
);

  // head word, shown before the pop (first-word fall-through)
  logic [DIN_WIDTH-1:0] rdata;
  // pop strobe from the reducer
  logic                 re;
  logic                 not_empty;
  logic                 full;
  logic                 almost_full;

  modport fifo_side (
    output rdata,
    output not_empty,
    output full,
    output almost_full,
    input  re
  );

  modport reducer_side (
    input  rdata,
    input  not_empty,
    input  full,
    input  almost_full,
    output re
  );

endinterface

//--- src/sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo #(
  parameter int DIN_WIDTH  = stream_pkg::DIN_WIDTH_DEF,
  parameter int FIFO_DEPTH = stream_pkg::FIFO_DEPTH_DEF,
  parameter int AF_MARGIN  = stream_pkg::AF_MARGIN_DEF
) (
  input  logic                 CLK,
  input  logic                 RESETN,
  input  logic [DIN_WIDTH-1:0] din,
  input  logic                 din_valid,
  output logic                 din_ready,
  output ctrl_pkg::cnt_t       drop_count,
  fifo_if.fifo_side            rd
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  // level is one bit wider than the pointers to tell full from empty
  localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W+1)'(FIFO_DEPTH);
  localparam logic [PTR_W:0] AF_LEVEL   = (PTR_W+1)'(FIFO_DEPTH - AF_MARGIN);

  logic [DIN_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W:0]       level;
  logic                 wr_en;
  logic                 rd_en;

  // a write into a full buffer is lost
  assign wr_en = din_valid & ~rd.full;
  assign rd_en = rd.re & rd.not_empty;

  assign rd.full        = (level == FULL_LEVEL);
  assign rd.almost_full = (level >= AF_LEVEL);
  assign rd.not_empty   = (level != '0);
  assign rd.rdata       = mem[rd_ptr];

  // storage
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      level <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // ready lags the level by one cycle, which the margin covers
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      din_ready <= 1'b0;
    end else begin
      din_ready <= ~rd.almost_full;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      drop_count <= '0;
    end else if (din_valid && rd.full) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

//--- src/width_reducer.sv
`timescale 1ns/10ps

module width_reducer #(
  parameter int DIN_WIDTH  = stream_pkg::DIN_WIDTH_DEF,
  parameter int DOUT_WIDTH = stream_pkg::DOUT_WIDTH_DEF
) (
  input  logic                  CLK,
  input  logic                  RESETN,
  fifo_if.reducer_side          rd,
  output logic [DOUT_WIDTH-1:0] slice_data,
  output logic                  slice_valid,
  output logic                  slice_last
);

  // slices per wide word
  localparam int RATIO = DIN_WIDTH / DOUT_WIDTH;
  localparam int IDX_W = (RATIO > 1) ? $clog2(RATIO) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(RATIO - 1);

  ctrl_pkg::reducer_state_e state;
  ctrl_pkg::reducer_state_e state_nxt;
  logic [DIN_WIDTH-1:0]     word;
  logic [IDX_W-1:0]         idx;
  logic                     at_last;
  logic                     pop;

  assign at_last = (state == ctrl_pkg::RED_SPLIT) && (idx == LAST_IDX);

  // pop from idle, or on the last slice so words stream without a gap
  assign pop = rd.not_empty &&
               ((state == ctrl_pkg::RED_IDLE) || at_last);

  assign rd.re = pop;

  always_comb begin
    state_nxt = state;
    case (state)
      ctrl_pkg::RED_IDLE: begin
        if (pop) begin
          state_nxt = ctrl_pkg::RED_SPLIT;
        end
      end
      ctrl_pkg::RED_SPLIT: begin
        if (at_last && !pop) begin
          state_nxt = ctrl_pkg::RED_IDLE;
        end
      end
      default: state_nxt = ctrl_pkg::RED_IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= ctrl_pkg::RED_IDLE;
      idx   <= '0;
    end else begin
      state <= state_nxt;
      if (pop || at_last) begin
        idx <= '0;
      end else if (state == ctrl_pkg::RED_SPLIT) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // word held for the whole split
  always_ff @(posedge CLK) begin
    if (pop) begin
      word <= rd.rdata;
    end
  end

  // lowest slice first
  assign slice_data  = word[idx*DOUT_WIDTH +: DOUT_WIDTH];
  assign slice_valid = (state == ctrl_pkg::RED_SPLIT);
  assign slice_last  = at_last;

endmodule

//--- src/slice_out_stage.sv
`timescale 1ns/10ps

module slice_out_stage #(
  parameter int DOUT_WIDTH = stream_pkg::DOUT_WIDTH_DEF
) (
  input  logic                  CLK,
  input  logic                  RESETN,
  input  logic [DOUT_WIDTH-1:0] slice_data,
  input  logic                  slice_valid,
  input  logic                  slice_last,
  output logic [DOUT_WIDTH-1:0] dout,
  output logic                  dout_valid,
  output logic                  dout_last,
  output ctrl_pkg::cnt_t        slice_count
);

  // output flags, one cycle behind the reducer
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      dout_valid <= 1'b0;
      dout_last  <= 1'b0;
    end else begin
      dout_valid <= slice_valid;
      dout_last  <= slice_valid & slice_last;
    end
  end

  // idle value is all ones, held between slices
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      dout <= {DOUT_WIDTH{1'b1}};
    end else if (slice_valid) begin
      dout <= slice_data;
    end
  end

  // delivered slices, wraps
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      slice_count <= '0;
    end else if (slice_valid) begin
      slice_count <= slice_count + 1'b1;
    end
  end

endmodule

//--- src/reducer_top.sv
`timescale 1ns/10ps

module reducer_top #(
  parameter int DIN_WIDTH  = stream_pkg::DIN_WIDTH_DEF,
  parameter int DOUT_WIDTH = stream_pkg::DOUT_WIDTH_DEF,
  parameter int FIFO_DEPTH = stream_pkg::FIFO_DEPTH_DEF,
  parameter int AF_MARGIN  = stream_pkg::AF_MARGIN_DEF
) (
  input  logic                  CLK,
  input  logic                  RESETN,
  input  logic [DIN_WIDTH-1:0]  din,
  input  logic                  din_valid,
  output logic                  din_ready,
  output logic [DOUT_WIDTH-1:0] dout,
  output logic                  dout_valid,
  output logic                  dout_last,
  output ctrl_pkg::cnt_t        slice_count,
  output ctrl_pkg::cnt_t        drop_count
);

  // reducer to output stage
  logic [DOUT_WIDTH-1:0] slice_data;
  logic                  slice_valid;
  logic                  slice_last;

  fifo_if #(.DIN_WIDTH(DIN_WIDTH)) fifo_link ();

  sample_fifo #(
    .DIN_WIDTH  (DIN_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH),
    .AF_MARGIN  (AF_MARGIN)
  ) sample_fifo_i (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .din        (din),
    .din_valid  (din_valid),
    .din_ready  (din_ready),
    .drop_count (drop_count),
    .rd         (fifo_link.fifo_side)
  );

  width_reducer #(
    .DIN_WIDTH  (DIN_WIDTH),
    .DOUT_WIDTH (DOUT_WIDTH)
  ) width_reducer_i (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .rd          (fifo_link.reducer_side),
    .slice_data  (slice_data),
    .slice_valid (slice_valid),
    .slice_last  (slice_last)
  );

  slice_out_stage #(
    .DOUT_WIDTH (DOUT_WIDTH)
  ) slice_out_stage_i (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .slice_data  (slice_data),
    .slice_valid (slice_valid),
    .slice_last  (slice_last),
    .dout        (dout),
    .dout_valid  (dout_valid),
    .dout_last   (dout_last),
    .slice_count (slice_count)
  );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic RESETN
);

  // 4 ns period
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // released 1 ns after an edge, like the other inputs
  initial begin
    RESETN = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RESETN = 1'b1;
  end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/10ps

module tb_top;

  localparam int RATIO    = stream_pkg::DIN_WIDTH_DEF / stream_pkg::DOUT_WIDTH_DEF;
  localparam int DEPTH    = stream_pkg::FIFO_DEPTH_DEF;
  localparam int AF_LEVEL = DEPTH - stream_pkg::AF_MARGIN_DEF;
  localparam int TIMEOUT  = 200;

  logic              CLK;
  logic              RESETN;
  stream_pkg::din_t  din;
  logic              din_valid;
  logic              din_ready;
  stream_pkg::dout_t dout;
  logic              dout_valid;
  logic              dout_last;
  ctrl_pkg::cnt_t    slice_count;
  ctrl_pkg::cnt_t    drop_count;

  // reference state as it stands after the last clock edge
  int               m_level;
  int               m_idx;
  logic             m_split;
  logic             m_ready;
  logic             m_dvalid;
  ctrl_pkg::cnt_t   m_drops;
  ctrl_pkg::cnt_t   m_slices;
  stream_pkg::din_t exp_q[$];
  stream_pkg::din_t cur_word;
  int               out_idx;
  int               accepted   = 0;
  int               words_done = 0;

  int          slice_errs = 0;
  int          flag_errs  = 0;
  int          count_errs = 0;
  int          other_errs = 0;
  logic [31:0] lcg_state  = 32'h521b96ea;

  clock_gen clock_gen_i (
    .CLK    (CLK),
    .RESETN (RESETN)
  );

  reducer_top dut_i (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // two draws make one wide word
  task automatic next_word(output stream_pkg::din_t w);
    logic [31:0] hi;
    hi        = lcg_step(lcg_state);
    lcg_state = lcg_step(hi);
    w         = {hi, lcg_state};
  endtask

  // field number index of the word, field 0 in the low bits
  function automatic stream_pkg::dout_t expected_slice(input stream_pkg::din_t word,
                                                       input int index);
    return stream_pkg::dout_t'(word >> (index * stream_pkg::DOUT_WIDTH_DEF));
  endfunction

  task automatic check_slice(input string name, input stream_pkg::dout_t got,
                             input stream_pkg::dout_t exp);
    if (got !== exp) begin
      slice_errs++;
      $display("CHECK FAILED %s: got %h, expected %h (t=%0t)", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("CHECK FAILED %s: got %h, expected %h (t=%0t)", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input ctrl_pkg::cnt_t got,
                             input ctrl_pkg::cnt_t exp);
    if (got !== exp) begin
      count_errs++;
      $display("CHECK FAILED %s: got %h, expected %h (t=%0t)", name, got, exp, $time);
    end
  endtask

  task automatic report_problem(input string msg);
    other_errs++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    @(posedge CLK);
    while (RESETN !== 1'b1 && n < TIMEOUT) begin
      @(posedge CLK);
      n++;
    end
    #1;
    if (RESETN !== 1'b1) report_problem("reset was never released");
  endtask

  // all accepted words delivered and din_ready back high
  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while ((words_done != accepted || din_ready !== 1'b1) && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (words_done != accepted || din_ready !== 1'b1) begin
      report_problem({"timed out waiting for the output to drain after ", what});
    end
  endtask

  // outputs sampled before the edge, then the model steps over the same edge
  always @(posedge CLK) begin : model_and_compare
    logic wr;
    logic pop;
    logic last;
    if (RESETN !== 1'b1) begin
      m_level  = 0;
      m_idx    = 0;
      m_split  = 1'b0;
      m_ready  = 1'b0;
      m_dvalid = 1'b0;
      m_drops  = '0;
      m_slices = '0;
      out_idx  = 0;
    end else begin
      check_flag("dout_valid", dout_valid, m_dvalid);
      check_flag("din_ready", din_ready, m_ready);
      check_count("drop_count", drop_count, m_drops);
      check_count("slice_count", slice_count, m_slices);
      if (dout_valid) begin
        if (out_idx == 0) begin
          if (exp_q.size() == 0) begin
            report_problem("dout_valid came with no accepted word waiting");
          end else begin
            cur_word = exp_q.pop_front();
          end
        end
        check_slice("dout", dout, expected_slice(cur_word, out_idx));
        check_flag("dout_last", dout_last, out_idx == RATIO - 1);
        if (out_idx == RATIO - 1) begin
          out_idx = 0;
          words_done++;
        end else begin
          out_idx++;
        end
      end else begin
        check_flag("dout_last", dout_last, 1'b0);
      end
      // buffer level and splitter step
      wr   = din_valid && (m_level < DEPTH);
      last = m_split && (m_idx == RATIO - 1);
      pop  = (m_level != 0) && (!m_split || last);
      m_ready  = (m_level < AF_LEVEL);
      m_dvalid = m_split;
      if (m_split) m_slices++;
      if (wr) begin
        exp_q.push_back(din);
        accepted++;
      end else if (din_valid) begin
        m_drops++;
      end
      m_level = m_level + int'(wr) - int'(pop);
      if (pop || last) begin
        m_split = pop;
        m_idx   = 0;
      end else if (m_split) begin
        m_idx++;
      end
    end
  end

  initial begin : stimulus
    int n;
    int sent;
    din       = '0;
    din_valid = 1'b0;
    wait_reset();

    check_flag("dout_valid", dout_valid, 1'b0);
    check_flag("dout_last", dout_last, 1'b0);
    check_slice("dout", dout, '1);
    check_count("slice_count", slice_count, '0);
    check_count("drop_count", drop_count, '0);
    wait_idle("reset");

    // lone words with idle gaps
    repeat (3) begin
      next_word(din);
      din_valid = 1'b1;
      next_cycle();
      din_valid = 1'b0;
      wait_idle("a single word");
      repeat (3) next_cycle();
    end

    // random burst that follows din_ready
    sent = 0;
    n    = 0;
    while (sent < 12 && n < TIMEOUT) begin
      if (din_ready) begin
        next_word(din);
        sent++;
      end
      din_valid = din_ready;
      next_cycle();
      n++;
    end
    din_valid = 1'b0;
    if (sent < 12) report_problem("the ready burst could not send all its words");
    wait_idle("the ready burst");
    check_count("slice_count", slice_count, ctrl_pkg::cnt_t'(accepted * RATIO));
    check_count("drop_count", drop_count, '0);

    // fill until din_ready falls, then overrun with 20 writes
    n = 0;
    while (din_ready === 1'b1 && n < TIMEOUT) begin
      next_word(din);
      din_valid = 1'b1;
      next_cycle();
      n++;
    end
    if (din_ready !== 1'b0) report_problem("din_ready never fell while filling");
    repeat (20) begin
      next_word(din);
      din_valid = 1'b1;
      next_cycle();
    end
    din_valid = 1'b0;
    wait_idle("the overflow burst");
    check_count("drop_count", drop_count, m_drops);
    check_count("slice_count", slice_count, ctrl_pkg::cnt_t'(accepted * RATIO));
    if (m_drops == '0) report_problem("the overflow burst dropped no writes");
    repeat (4) next_cycle();

    $display("errors: slice %0d, flag %0d, count %0d, other %0d",
             slice_errs, flag_errs, count_errs, other_errs);
    if (slice_errs + flag_errs + count_errs + other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
src/stream_pkg.sv
src/ctrl_pkg.sv
src/fifo_if.sv
src/sample_fifo.sv
src/width_reducer.sv
src/slice_out_stage.sv
src/reducer_top.sv
bench/clock_gen.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -j 0 --top-module tb_top -f build.f

out=$(./obj_dir/Vtb_top)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
